//--- phys_port_traffic.f
+incdir+verilog
verilog/phys_port_pkg.sv
verilog/axis_pkt_gen.sv
verilog/port_frame_stats.sv
verilog/phys_port_traffic_top.sv
sim/phys_port_traffic_sva.sv
sim/phys_port_traffic_tb.sv

//--- Makefile
# Verilator build and run of the physical-port traffic testbench

VERILATOR ?= verilator
TOP       ?= phys_port_traffic_tb
FILELIST  ?= phys_port_traffic.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/phys_port_traffic_tb.sv
////////////////////////////////////////////////////////////////////////////
// Both ports run concurrently, one packet in flight each; stats enable
// only changes while both ports are idle, so a packet counts whole or not
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "phys_port_config.svh"

module phys_port_traffic_tb
    import phys_port_pkg::*;
();

    // 20 random, 5 uncounted, 5 counted, 1 zero-length per port
    localparam int NUM_PACKETS = 31;
    localparam int CYCLE_LIMIT = NUM_PACKETS * (`MTU_BYTES + 8) * 4;

    logic        phys_port_clk_ifc = 1'b0;
    logic        rst;
    logic [1:0]  stats_enable;
    logic [1:0]  stats_clear;
    logic        send_req_8b, tready_8b, busy_8b, tvalid_8b, tlast_8b;
    logic        send_req_32b, tready_32b, busy_32b, tvalid_32b, tlast_32b;
    byte_len_t   byte_len_8b, byte_len_32b;
    logic [7:0]  first_byte_8b, first_byte_32b;
    word8_t      tdata_8b;
    word32_t     tdata_32b;
    logic [0:0]  tkeep_8b;
    logic [3:0]  tkeep_32b;
    stat_count_t frame_count_8b, byte_count_8b, frame_count_32b, byte_count_32b;

    // Model state, index 0 is the 8-bit port
    integer      seed = 56300;
    int          cycle_count = 0;
    int          to_send [2];
    int          cur_len [2];
    int          cur_off [2];
    logic [7:0]  cur_first [2];
    logic        req [2];
    logic        ready [2];
    logic        busy_s [2];
    logic        stalled [2];
    logic [31:0] held_data [2];
    logic [5:0]  held_ctrl [2];
    stat_count_t exp_frames [2];
    stat_count_t exp_bytes [2];
    string       port_name [2] = '{"8b", "32b"};

    phys_port_traffic_top u_phys_port_traffic_top (.*);

    always #20 phys_port_clk_ifc = ~phys_port_clk_ifc;

    ////////////////////////////////////////////////////////////////////////////
    // Checking helpers

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            fail_run("Value mismatch");
        end
    endtask

    task automatic tick();
        @(posedge phys_port_clk_ifc);
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            fail_run($sformatf("Timeout after %0d cycles, a port never went idle",
                               cycle_count));
        end
    endtask

    function automatic int word_bytes(input int p);
        return (p == 0) ? 1 : 4;
    endfunction

    // Expected word from the incrementing-byte rule, valid lanes only
    task automatic check_word(input int p, input logic [31:0] data,
                              input logic [3:0] keep, input logic last);
        int          left;
        int          n;
        logic [31:0] exp_data;
        logic [31:0] mask;
        left = cur_len[p] - cur_off[p];
        if (left <= 0) begin
            fail_run({"Transfer on port ", port_name[p], " with no packet outstanding"});
        end
        n        = (left < word_bytes(p)) ? left : word_bytes(p);
        exp_data = '0;
        mask     = '0;
        for (int i = 0; i < n; i++) begin
            exp_data[8*i +: 8] = cur_first[p] + 8'(cur_off[p] + i);
            mask[8*i +: 8]     = 8'hff;
        end
        check_value({"tkeep_", port_name[p]}, 32'(keep), 32'((1 << n) - 1));
        check_value({"tlast_", port_name[p]}, 32'(last), 32'(left <= word_bytes(p)));
        check_value({"tdata_", port_name[p]}, data & mask, exp_data);
        cur_off[p] += n;
    endtask

    task automatic check_counts();
        check_value("frame_count_8b", frame_count_8b, exp_frames[0]);
        check_value("byte_count_8b", byte_count_8b, exp_bytes[0]);
        check_value("frame_count_32b", frame_count_32b, exp_frames[1]);
        check_value("byte_count_32b", byte_count_32b, exp_bytes[1]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic issue_packet(input int p);
        int         len;
        logic [7:0] first;
        len          = 1 + ({$random(seed)} % `MTU_BYTES);
        first        = 8'($random(seed));
        cur_len[p]   = len;
        cur_off[p]   = 0;
        cur_first[p] = first;
        req[p]       = 1'b1;
        to_send[p]--;
        if (stats_enable[p]) begin
            exp_frames[p] += 1;
            exp_bytes[p]  += stat_count_t'(len);
        end
        if (p == 0) begin
            byte_len_8b   <= byte_len_t'(len);
            first_byte_8b <= first;
        end else begin
            byte_len_32b   <= byte_len_t'(len);
            first_byte_32b <= first;
        end
    endtask

    // One clock of traffic on both ports
    task automatic step_cycle();
        logic [31:0] data [2];
        logic [5:0]  ctrl [2];
        tick();
        data[0]   = 32'(tdata_8b);
        data[1]   = tdata_32b;
        ctrl[0]   = {tvalid_8b, tlast_8b, 3'b000, tkeep_8b};
        ctrl[1]   = {tvalid_32b, tlast_32b, tkeep_32b};
        busy_s[0] = busy_8b;
        busy_s[1] = busy_32b;
        for (int p = 0; p < 2; p++) begin
            // A stalled word must not move
            if (stalled[p]) begin
                check_value({"tdata_", port_name[p]}, data[p], held_data[p]);
                check_value({"tvalid_tlast_tkeep_", port_name[p]}, 32'(ctrl[p]),
                            32'(held_ctrl[p]));
            end
            if (ctrl[p][5] && ready[p]) begin
                check_word(p, data[p], ctrl[p][3:0], ctrl[p][4]);
            end
            stalled[p]   = ctrl[p][5] && !ready[p];
            held_data[p] = data[p];
            held_ctrl[p] = ctrl[p];
            if (req[p] && busy_s[p]) begin
                req[p] = 1'b0;
            end else if (!req[p] && !busy_s[p] && to_send[p] > 0) begin
                issue_packet(p);
            end
            ready[p] = ({$random(seed)} % 10) < 7;
        end
        send_req_8b  <= req[0];
        send_req_32b <= req[1];
        tready_8b    <= ready[0];
        tready_32b   <= ready[1];
    endtask

    task automatic run_packets(input int n);
        to_send[0] = n;
        to_send[1] = n;
        do begin
            step_cycle();
        end while (to_send[0] > 0 || to_send[1] > 0 || req[0] || req[1] ||
                   busy_s[0] || busy_s[1]);
    endtask

    task automatic check_quiet();
        check_value("busy_8b", 32'(busy_8b), 32'd0);
        check_value("tvalid_8b", 32'(tvalid_8b), 32'd0);
        check_value("tlast_8b", 32'(tlast_8b), 32'd0);
        check_value("busy_32b", 32'(busy_32b), 32'd0);
        check_value("tvalid_32b", 32'(tvalid_32b), 32'd0);
        check_value("tlast_32b", 32'(tlast_32b), 32'd0);
    endtask

    initial begin
        rst            = 1'b1;
        stats_enable   = 2'b11;
        stats_clear    = 2'b00;
        send_req_8b    = 1'b0;
        send_req_32b   = 1'b0;
        byte_len_8b    = '0;
        byte_len_32b   = '0;
        first_byte_8b  = '0;
        first_byte_32b = '0;
        tready_8b      = 1'b0;
        tready_32b     = 1'b0;
        for (int p = 0; p < 2; p++) begin
            to_send[p]    = 0;
            cur_len[p]    = 0;
            cur_off[p]    = 0;
            cur_first[p]  = '0;
            req[p]        = 1'b0;
            ready[p]      = 1'b0;
            busy_s[p]     = 1'b0;
            stalled[p]    = 1'b0;
            exp_frames[p] = '0;
            exp_bytes[p]  = '0;
        end
        repeat (3) tick();
        rst <= 1'b0;
        tick();
        check_quiet();
        check_counts();

        run_packets(20);
        check_counts();

        // 8-bit port stats off for a while
        stats_enable <= 2'b10;
        run_packets(5);
        stats_enable <= 2'b11;
        run_packets(5);
        check_counts();

        stats_clear <= 2'b11;
        tick();
        stats_clear <= 2'b00;
        tick();
        exp_frames = '{'0, '0};
        exp_bytes  = '{'0, '0};
        check_counts();

        // Zero-length requests are ignored
        send_req_8b  <= 1'b1;
        byte_len_8b  <= '0;
        send_req_32b <= 1'b1;
        byte_len_32b <= '0;
        repeat (4) begin
            tick();
            check_quiet();
        end
        send_req_8b  <= 1'b0;
        send_req_32b <= 1'b0;
        tick();
        check_counts();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- sim/phys_port_traffic_sva.sv
////////////////////////////////////////////////////////////////////////////
// Bound to every axis_pkt_gen; BYTES follows the generator's word width
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phys_port_traffic_sva #(
    parameter int BYTES = 1
) (
    input logic               phys_port_clk_ifc,
    input logic               rst,
    input logic               busy,
    input logic               tvalid,
    input logic               tready,
    input logic               tlast,
    input logic [8*BYTES-1:0] tdata,
    input logic [BYTES-1:0]   tkeep
);

    // Reset leaves the stream quiet
    assert property (@(posedge phys_port_clk_ifc) rst |=> !busy && !tvalid && !tlast)
        else $error("generator not idle after reset");

    // Stalled word holds until it transfers
    assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tkeep) && $stable(tlast))
        else $error("stream word changed while stalled");

    // Only the last word may be partial, and lane 0 always carries data
    assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        tvalid |-> tkeep[0] && (tlast || (&tkeep)))
        else $error("bad tkeep on a valid word");

endmodule

bind axis_pkt_gen phys_port_traffic_sva #(.BYTES(BYTES_PER_WORD)) u_sva (
    .phys_port_clk_ifc (phys_port_clk_ifc),
    .rst               (rst),
    .busy              (busy),
    .tvalid            (tvalid),
    .tready            (tready),
    .tlast             (tlast),
    .tdata             (tdata),
    .tkeep             (tkeep)
);

//--- verilog/phys_port_traffic_top.sv
////////////////////////////////////////////////////////////////////////////
// Two independent egress ports; bit 0 of the stats controls is the 8-bit one
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phys_port_traffic_top
    import phys_port_pkg::*;
(
    input  logic        phys_port_clk_ifc,
    input  logic        rst,
    input  logic [1:0]  stats_enable,
    input  logic [1:0]  stats_clear,

    // 8-bit port
    input  logic        send_req_8b,
    input  byte_len_t   byte_len_8b,
    input  logic [7:0]  first_byte_8b,
    input  logic        tready_8b,
    output logic        busy_8b,
    output word8_t      tdata_8b,
    output logic [0:0]  tkeep_8b,
    output logic        tvalid_8b,
    output logic        tlast_8b,
    output stat_count_t frame_count_8b,
    output stat_count_t byte_count_8b,

    // 32-bit port
    input  logic        send_req_32b,
    input  byte_len_t   byte_len_32b,
    input  logic [7:0]  first_byte_32b,
    input  logic        tready_32b,
    output logic        busy_32b,
    output word32_t     tdata_32b,
    output logic [3:0]  tkeep_32b,
    output logic        tvalid_32b,
    output logic        tlast_32b,
    output stat_count_t frame_count_32b,
    output stat_count_t byte_count_32b
);

    ////////////////////////////////////////////////////////////////////////////
    // 8-bit port

    axis_pkt_gen #(.word_t(word8_t)) u_pkt_gen_8b (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst               (rst),
        .send_req          (send_req_8b),
        .byte_len          (byte_len_8b),
        .first_byte        (first_byte_8b),
        .busy              (busy_8b),
        .tdata             (tdata_8b),
        .tkeep             (tkeep_8b),
        .tvalid            (tvalid_8b),
        .tlast             (tlast_8b),
        .tready            (tready_8b)
    );

    port_frame_stats #(.word_t(word8_t)) u_stats_8b (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst               (rst),
        .enable            (stats_enable[0]),
        .clear             (stats_clear[0]),
        .tvalid            (tvalid_8b),
        .tready            (tready_8b),
        .tlast             (tlast_8b),
        .tkeep             (tkeep_8b),
        .frame_count       (frame_count_8b),
        .byte_count        (byte_count_8b)
    );

    ////////////////////////////////////////////////////////////////////////////
    // 32-bit port

    axis_pkt_gen #(.word_t(word32_t)) u_pkt_gen_32b (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst               (rst),
        .send_req          (send_req_32b),
        .byte_len          (byte_len_32b),
        .first_byte        (first_byte_32b),
        .busy              (busy_32b),
        .tdata             (tdata_32b),
        .tkeep             (tkeep_32b),
        .tvalid            (tvalid_32b),
        .tlast             (tlast_32b),
        .tready            (tready_32b)
    );

    port_frame_stats #(.word_t(word32_t)) u_stats_32b (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst               (rst),
        .enable            (stats_enable[1]),
        .clear             (stats_clear[1]),
        .tvalid            (tvalid_32b),
        .tready            (tready_32b),
        .tlast             (tlast_32b),
        .tkeep             (tkeep_32b),
        .frame_count       (frame_count_32b),
        .byte_count        (byte_count_32b)
    );

endmodule

//--- verilog/port_frame_stats.sv
////////////////////////////////////////////////////////////////////////////
// Counts only on valid && ready; clear wins over counting in the same cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module port_frame_stats
    import phys_port_pkg::*;
#(
    parameter type word_t = word8_t
) (
    input  logic                       phys_port_clk_ifc,
    input  logic                       rst,
    input  logic                       enable,
    input  logic                       clear,

    // Observed stream
    input  logic                       tvalid,
    input  logic                       tready,
    input  logic                       tlast,
    input  logic [$bits(word_t)/8-1:0] tkeep,

    output stat_count_t                frame_count,
    output stat_count_t                byte_count
);

    localparam int BYTES_PER_WORD = $bits(word_t) / 8;
    localparam int KEEP_SUM_BITS  = $clog2(BYTES_PER_WORD + 1);

    logic                     xfer;
    logic [KEEP_SUM_BITS-1:0] keep_sum;

    assign xfer = tvalid && tready;

    // Number of valid bytes in this word
    always_comb begin
        keep_sum = '0;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            keep_sum = keep_sum + KEEP_SUM_BITS'(tkeep[i]);
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst || clear) begin
            frame_count <= '0;
            byte_count  <= '0;
        end else if (enable && xfer) begin
            byte_count <= byte_count + stat_count_t'(keep_sum);
            if (tlast) begin
                frame_count <= frame_count + stat_count_t'(1);
            end
        end
    end

endmodule

//--- verilog/axis_pkt_gen.sv
////////////////////////////////////////////////////////////////////////////
// Holds one packet in flight; send_req is a level, dropped once busy is seen
// Zero-length requests are ignored; word_t must be a whole number of bytes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axis_pkt_gen
    import phys_port_pkg::*;
#(
    parameter type word_t = word8_t
) (
    input  logic                       phys_port_clk_ifc,
    input  logic                       rst,

    // Request side
    input  logic                       send_req,
    input  byte_len_t                  byte_len,
    input  logic [7:0]                 first_byte,
    output logic                       busy,

    // Egress stream
    output word_t                      tdata,
    output logic [$bits(word_t)/8-1:0] tkeep,
    output logic                       tvalid,
    output logic                       tlast,
    input  logic                       tready
);

    localparam int        WORD_BITS      = $bits(word_t);
    localparam int        BYTES_PER_WORD = WORD_BITS / 8;
    localparam byte_len_t WORD_STEP      = byte_len_t'(BYTES_PER_WORD);

    typedef enum logic {
        IDLE,
        SENDING
    } state_t;

    state_t               state;
    byte_len_t            remaining;
    logic [7:0]           next_byte;
    logic [WORD_BITS-1:0] word_bits;
    logic                 accept;
    logic                 xfer;
    logic                 last_word;

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes

    assign accept    = (state == IDLE) && send_req && (byte_len != '0);
    assign xfer      = tvalid && tready;
    // Bytes left fit in the current word
    assign last_word = (remaining <= WORD_STEP);

    ////////////////////////////////////////////////////////////////////////////
    // FSM and remaining-byte counter

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            state     <= IDLE;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state     <= SENDING;
                        remaining <= byte_len;
                    end
                end
                SENDING: begin
                    if (xfer) begin
                        if (last_word) begin
                            state <= IDLE;
                        end else begin
                            remaining <= remaining - WORD_STEP;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // First byte of the word on the bus
    always_ff @(posedge phys_port_clk_ifc) begin
        if (accept) begin
            next_byte <= first_byte;
        end else if (xfer) begin
            next_byte <= next_byte + 8'(BYTES_PER_WORD);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word assembly

    // Incrementing bytes, lowest lane first; keep marks lanes still owed
    always_comb begin
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            word_bits[8*i +: 8] = next_byte + 8'(i);
            tkeep[i]            = (remaining > byte_len_t'(i));
        end
    end

    assign tdata  = word_t'(word_bits);
    assign tvalid = (state == SENDING);
    assign tlast  = tvalid && last_word;
    assign busy   = (state == SENDING);

endmodule

//--- verilog/phys_port_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types shared by the generators, statistics and the top level
// Stream words carry byte 0 in the lowest 8 bits
////////////////////////////////////////////////////////////////////////////

`include "phys_port_config.svh"

package phys_port_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Lengths and counters

    // Packet length in bytes, zero means no packet
    typedef logic [`BYTE_LEN_WIDTH-1:0] byte_len_t;

    // One frame or byte count
    typedef logic [`STAT_COUNT_WIDTH-1:0] stat_count_t;

    ////////////////////////////////////////////////////////////////////////////
    // Stream words

    // 8-bit port, one byte per word
    typedef logic [7:0] word8_t;

    // 32-bit port, four bytes per word
    typedef logic [31:0] word32_t;

endpackage

//--- verilog/phys_port_config.svh
////////////////////////////////////////////////////////////////////////////
// Packet lengths run from 1 to MTU_BYTES and must fit in BYTE_LEN_WIDTH
// Counters wrap silently at STAT_COUNT_WIDTH bits
////////////////////////////////////////////////////////////////////////////

`ifndef PHYS_PORT_CONFIG_SVH
`define PHYS_PORT_CONFIG_SVH

// Largest packet a generator will send, in bytes
`define MTU_BYTES 256

// Byte length field, wide enough to hold MTU_BYTES itself
`define BYTE_LEN_WIDTH 9

// Frame and byte counters
`define STAT_COUNT_WIDTH 32

`endif
